//--- Bender.yml
package:
  name: irig_b_decoder

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/irig_sym_pkg.sv
      - verilog/irig_time_pkg.sv
      - verilog/irig_symbol_decode.sv
      - verilog/irig_frame_execute.sv
      - verilog/irig_time_result.sv
      - verilog/irig_b_decoder_top.sv

  - target: test
    files:
      - tests/irig_b_decoder_props.sv
      - tests/tb_irig_b_decoder.sv

//--- irig_b_decoder_top.f
+incdir+verilog
verilog/irig_sym_pkg.sv
verilog/irig_time_pkg.sv
verilog/irig_symbol_decode.sv
verilog/irig_frame_execute.sv
verilog/irig_time_result.sv
verilog/irig_b_decoder_top.sv
tests/irig_b_decoder_props.sv
tests/tb_irig_b_decoder.sv

//--- tests/irig_b_decoder_props.sv
`timescale 1ns/1ps

module irig_b_decoder_props (
	input logic                      clk_125mhz,
	input logic                      rst_n,
	input logic                      frame_done,
	input logic                      tm_valid,
	input logic                      tm_ready,
	input irig_time_pkg::sec_bcd_t   tm_sec,
	input irig_time_pkg::min_bcd_t   tm_min,
	input irig_time_pkg::hour_bcd_t  tm_hour,
	input irig_time_pkg::day_bcd_t   tm_day,
	input irig_time_pkg::year_bcd_t  tm_year,
	input logic                      frame_err,
	input logic                      overrun
);

	logic [37:0] rec;
	int          fail_cnt = 0;

	assign rec = {tm_sec, tm_min, tm_hour, tm_day, tm_year};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	hold_until_taken: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		tm_valid && !tm_ready |=> tm_valid && ($stable(rec) || overrun))
		else begin
			fail_cnt++;
			$error("record dropped or changed while waiting for tm_ready");
		end

	err_or_record: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		frame_done |=> !frame_err || (!$rose(tm_valid) && $stable(rec)))
		else begin
			fail_cnt++;
			$error("one frame gave both frame_err and a new record");
		end

	overrun_needs_valid: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		overrun |-> tm_valid && $past(tm_valid && !tm_ready))   // held record was lost
		else begin
			fail_cnt++;
			$error("overrun pulsed without a held record waiting");
		end

endmodule

bind irig_time_result irig_b_decoder_props u_props (.*);

//--- tests/irig_stim.txt
# columns: sec min hour day year fault stall expect, all decimal
# fault 0 none 1 marker moved 2 wide element 3 out of range; expect 0 record 1 error 2 overrun
12 34 5 123 24 0 0 0
59 59 23 366 99 0 0 0
0 0 0 1 0 0 0 0
47 21 16 200 37 0 0 0
38 46 19 99 81 0 0 0
8 45 9 88 50 1 0 1
30 15 11 250 10 0 0 0
31 16 12 251 11 2 0 1
33 17 13 252 12 0 0 0
10 75 3 45 21 3 0 1
11 20 24 45 21 3 0 1
25 52 14 317 63 0 0 0
1 2 3 4 5 0 1 0
6 7 8 9 10 0 1 2
19 28 17 301 88 0 0 0
54 43 22 170 42 0 0 0

//--- tests/tb_irig_b_decoder.sv
`timescale 1ns/1ps

`include "irig_defines.svh"

module tb_irig_b_decoder;

	localparam int MAX_LINES = 64;

	logic        clk_125mhz;
	logic        rst_n;
	logic        irig_in;
	logic        tm_ready;
	logic        tm_valid;
	logic [6:0]  tm_sec;
	logic [6:0]  tm_min;
	logic [5:0]  tm_hour;
	logic [9:0]  tm_day;
	logic [7:0]  tm_year;
	logic        frame_err;
	logic        overrun;

	logic [31:0] lfsr;
	int          stim [MAX_LINES][8];   // sec min hour day year fault stall expect
	int          n_frames;
	int          err_seen;
	int          ovr_seen;
	int          exp_err;
	int          exp_ovr;
	logic [37:0] last_rec;
	logic [37:0] exp_q [$];

	irig_b_decoder_top DUT (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.irig_in    (irig_in),
		.tm_valid   (tm_valid),
		.tm_ready   (tm_ready),
		.tm_sec     (tm_sec),
		.tm_min     (tm_min),
		.tm_hour    (tm_hour),
		.tm_day     (tm_day),
		.tm_year    (tm_year),
		.frame_err  (frame_err),
		.overrun    (overrun)
	);

	always #4 clk_125mhz = ~clk_125mhz;   // 125 MHz

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output int r);
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = (r << 1) | int'(lfsr[0]);
		end
	endtask

	// element bits of one frame with each digit lsb first
	function automatic logic [99:0] frame_bits(input int s, m, h, d, y);
		logic [99:0] v;
		v        = '0;
		v[4:1]   = 4'(s % 10);
		v[8:6]   = 3'(s / 10);
		v[13:10] = 4'(m % 10);
		v[17:15] = 3'(m / 10);
		v[23:20] = 4'(h % 10);
		v[26:25] = 2'(h / 10);
		v[33:30] = 4'(d % 10);
		v[38:35] = 4'((d / 10) % 10);
		v[41:40] = 2'(d / 100);
		v[53:50] = 4'(y % 10);
		v[58:55] = 4'(y / 10);
		return v;
	endfunction

	function automatic logic [37:0] bcd_record(input int s, m, h, d, y);
		return {3'(s / 10), 4'(s % 10), 3'(m / 10), 4'(m % 10), 2'(h / 10), 4'(h % 10),
			2'(d / 100), 4'((d / 10) % 10), 4'(d % 10), 4'(y / 10), 4'(y % 10)};
	endfunction

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("ERR @%0t: %s, got %0h expected %0h", $time, msg, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic take_record();
		check_val(exp_q.size() > 0, 1, "record transferred with none pending");
		check_val({tm_sec, tm_min, tm_hour, tm_day, tm_year}, exp_q.pop_front(),
			"transferred record fields");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line driver and output monitor for one clock
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic drive_cycle(input logic level, input logic rdy);
		@(negedge clk_125mhz);
		irig_in  = level;
		tm_ready = rdy;
		check_val(DUT.u_time_result.u_props.fail_cnt, 0, "bound assertion failures");
		if (frame_err)
			err_seen++;
		if (overrun)
			ovr_seen++;
		if (tm_valid && tm_ready)
			take_record();   // transfer on the coming rising edge
	endtask

	task automatic send_elem(input int high, input logic stall, input int idx);
		int rnd;
		logic rdy;
		for (int c = 0; c < `IRIG_ELEM_CLKS; c++) begin
			if (stall) begin
				rdy = 1'b0;
			end else if (idx >= 90) begin
				rdy = 1'b1;   // ready settles before the record arrives
			end else begin
				rand_bits(1, rnd);
				rdy = rnd[0];
			end
			drive_cycle(c < high, rdy);
		end
	endtask

	task automatic run_frame(input int i);
		logic [99:0] bits;
		logic [37:0] rec;
		int          jit;
		int          high;
		bits = frame_bits(stim[i][0], stim[i][1], stim[i][2], stim[i][3], stim[i][4]);
		rec  = bcd_record(stim[i][0], stim[i][1], stim[i][2], stim[i][3], stim[i][4]);
		if (stim[i][7] == 2 || (stim[i][7] == 0 && stim[i][6] == 0))
			exp_q.push_back(rec);   // stalled record is overwritten by the next frame
		for (int e = 0; e < 100; e++) begin
			rand_bits(2, jit);
			if (e == 0 || e % 10 == 9 || (stim[i][5] == 1 && e == 44))
				high = 80 + jit;
			else if (stim[i][5] == 2 && e == 44)
				high = `IRIG_THR_MAX + 2;
			else
				high = bits[e] ? 50 + jit : 20 + jit;
			send_elem(high, stim[i][6] != 0, e);
		end
		if (stim[i][7] == 1)
			exp_err++;
		else
			last_rec = rec;
		if (stim[i][7] == 2)
			exp_ovr++;
		check_val(err_seen, exp_err, $sformatf("frame %0d frame_err count", i));
		check_val(ovr_seen, exp_ovr, $sformatf("frame %0d overrun count", i));
		check_val(tm_valid, stim[i][6] != 0, $sformatf("frame %0d tm_valid at end", i));
		check_val({tm_sec, tm_min, tm_hour, tm_day, tm_year}, last_rec,
			$sformatf("frame %0d held record", i));
		if (stim[i][6] == 0)
			check_val(exp_q.size(), 0, $sformatf("frame %0d record never transferred", i));
	endtask

	task automatic check_idle(input string where);
		check_val(tm_valid, 0, {"tm_valid ", where});
		check_val({frame_err, overrun}, 0, {"frame_err or overrun ", where});
		check_val(err_seen + ovr_seen, 0, {"error pulses seen ", where});
		check_val({tm_sec, tm_min, tm_hour, tm_day, tm_year}, 0, {"record fields ", where});
	endtask

	task automatic load_stim();
		int    fd;
		int    n;
		int    cnt;
		int    v [8];
		string line;
		cnt = 0;
		fd  = $fopen("tests/irig_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tests/irig_stim.txt");
			$display("Simulation FAILED");
			$fatal(1);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%d %d %d %d %d %d %d %d",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
					if (n != 8 || cnt >= MAX_LINES) begin
						$display("stimulus line %0d is malformed or beyond the limit", cnt);
						$display("Simulation FAILED");
						$fatal(1);
					end else begin
						stim[cnt] = v;
						cnt++;
					end
				end
			end
			$fclose(fd);
			n_frames = cnt;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk_125mhz = 1'b0;
		rst_n      = 1'b0;
		irig_in    = 1'b0;
		tm_ready   = 1'b0;
		lfsr       = 32'hfa28c47c;
		n_frames   = 0;
		err_seen   = 0;
		ovr_seen   = 0;
		exp_err    = 0;
		exp_ovr    = 0;
		last_rec   = '0;
		load_stim();
		repeat (10) @(negedge clk_125mhz);
		rst_n = 1'b1;
		check_idle("after reset");
		send_elem(80, 1'b0, 99);   // lone marker opens the first pair
		check_idle("before first frame");
		for (int i = 0; i < n_frames; i++)
			run_frame(i);
		$display("Simulation PASSED");
		$finish;
	end

	initial begin
		wait (n_frames > 0);
		#((n_frames + 2) * 100 * `IRIG_ELEM_CLKS * 8);
		$display("timeout: the %0d stimulus frames did not finish in time", n_frames);
		$display("Simulation FAILED");
		$fatal(1);
	end

endmodule

//--- verilog/irig_b_decoder_top.sv
`timescale 1ns/1ps

module irig_b_decoder_top (
	input  logic                      clk_125mhz,
	input  logic                      rst_n,
	input  logic                      irig_in,
	output logic                      tm_valid,
	input  logic                      tm_ready,
	output irig_time_pkg::sec_bcd_t   tm_sec,
	output irig_time_pkg::min_bcd_t   tm_min,
	output irig_time_pkg::hour_bcd_t  tm_hour,
	output irig_time_pkg::day_bcd_t   tm_day,
	output irig_time_pkg::year_bcd_t  tm_year,
	output logic                      frame_err,
	output logic                      overrun
);

	logic                     sym_valid;
	irig_sym_pkg::sym_e       sym;
	logic                     frame_done;
	logic                     frame_ok;
	irig_time_pkg::sec_bcd_t  sec;
	irig_time_pkg::min_bcd_t  min;
	irig_time_pkg::hour_bcd_t hour;
	irig_time_pkg::day_bcd_t  day;
	irig_time_pkg::year_bcd_t year;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line -> symbols -> frame -> record
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	irig_symbol_decode u_symbol_decode (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.irig_in    (irig_in),
		.sym_valid  (sym_valid),
		.sym        (sym)
	);

	irig_frame_execute u_frame_execute (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.sym_valid  (sym_valid),
		.sym        (sym),
		.frame_done (frame_done),
		.frame_ok   (frame_ok),
		.sec        (sec),
		.min        (min),
		.hour       (hour),
		.day        (day),
		.year       (year)
	);

	irig_time_result u_time_result (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.frame_done (frame_done),
		.frame_ok   (frame_ok),
		.sec        (sec),
		.min        (min),
		.hour       (hour),
		.day        (day),
		.year       (year),
		.tm_valid   (tm_valid),
		.tm_ready   (tm_ready),
		.tm_sec     (tm_sec),
		.tm_min     (tm_min),
		.tm_hour    (tm_hour),
		.tm_day     (tm_day),
		.tm_year    (tm_year),
		.frame_err  (frame_err),
		.overrun    (overrun)
	);

endmodule

//--- verilog/irig_defines.svh
`ifndef IRIG_DEFINES_SVH
`define IRIG_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// element timing, in clk_125mhz cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IRIG_ELEM_CLKS 100   // 1250000 for a real 10 ms element

// high-time class limits
`define IRIG_THR_01    35    // below: zero
`define IRIG_THR_1P    65    // below: one
`define IRIG_THR_MAX   95    // below: marker, else bad

// high-time counter width, wide enough for a full element at 125 MHz
`define IRIG_CNT_W     24

`endif

//--- verilog/irig_frame_execute.sv
`timescale 1ns/1ps

module irig_frame_execute (
	input  logic                      clk_125mhz,
	input  logic                      rst_n,
	input  logic                      sym_valid,
	input  irig_sym_pkg::sym_e        sym,
	output logic                      frame_done,
	output logic                      frame_ok,
	output irig_time_pkg::sec_bcd_t   sec,
	output irig_time_pkg::min_bcd_t   min,
	output irig_time_pkg::hour_bcd_t  hour,
	output irig_time_pkg::day_bcd_t   day,
	output irig_time_pkg::year_bcd_t  year
);

	logic       synced;
	logic       prev_mark;
	logic       ok_acc;
	logic [3:0] idx_tens;    // element index as two decimal digits
	logic [3:0] idx_units;
	logic       is_mark;
	logic       bit_in;
	logic       slot_mark;
	logic       last_elem;
	logic       elem_ok;
	logic       take;

	irig_time_pkg::sec_bcd_t  sec_c;
	irig_time_pkg::min_bcd_t  min_c;
	irig_time_pkg::hour_bcd_t hour_c;
	irig_time_pkg::day_bcd_t  day_c;
	irig_time_pkg::year_bcd_t year_c;

	assign is_mark   = (sym == irig_sym_pkg::sym_mark);
	assign bit_in    = (sym == irig_sym_pkg::sym_one);
	assign slot_mark = (idx_units == 4'd9);
	assign last_elem = slot_mark && (idx_tens == 4'd9);
	assign elem_ok   = (sym != irig_sym_pkg::sym_bad) && (is_mark == slot_mark);
	assign take      = sym_valid && synced;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame sync and element index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			synced     <= 1'b0;
			prev_mark  <= 1'b0;
			ok_acc     <= 1'b0;
			idx_tens   <= 4'd0;
			idx_units  <= 4'd0;
			frame_done <= 1'b0;
			frame_ok   <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (sym_valid) begin
				prev_mark <= is_mark;   // element 99 doubles as first marker of next pair
				if (!synced) begin
					if (is_mark && prev_mark) begin
						synced    <= 1'b1;
						ok_acc    <= 1'b1;
						idx_tens  <= 4'd0;
						idx_units <= 4'd1;   // this marker is element 0
					end
				end else begin
					ok_acc <= ok_acc && elem_ok;
					if (last_elem) begin
						synced     <= 1'b0;
						frame_done <= 1'b1;
						frame_ok   <= ok_acc && elem_ok;
					end else if (slot_mark) begin
						idx_units <= 4'd0;
						idx_tens  <= idx_tens + 4'd1;
					end else begin
						idx_units <= idx_units + 4'd1;
					end
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// BCD collection, lsb first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_125mhz) begin
		if (take && !slot_mark) begin
			case (idx_tens)
				4'd0: begin
					if (idx_units inside {[4'd1:4'd4]})
						sec_c.units <= {bit_in, sec_c.units[3:1]};
					else if (idx_units inside {[4'd6:4'd8]})
						sec_c.tens <= {bit_in, sec_c.tens[2:1]};
				end
				4'd1: begin
					if (idx_units <= 4'd3)
						min_c.units <= {bit_in, min_c.units[3:1]};
					else if (idx_units inside {[4'd5:4'd7]})
						min_c.tens <= {bit_in, min_c.tens[2:1]};
				end
				4'd2: begin
					if (idx_units <= 4'd3)
						hour_c.units <= {bit_in, hour_c.units[3:1]};
					else if (idx_units inside {[4'd5:4'd6]})
						hour_c.tens <= {bit_in, hour_c.tens[1]};
				end
				4'd3: begin
					if (idx_units <= 4'd3)
						day_c.units <= {bit_in, day_c.units[3:1]};
					else if (idx_units inside {[4'd5:4'd8]})
						day_c.tens <= {bit_in, day_c.tens[3:1]};
				end
				4'd4: begin
					if (idx_units <= 4'd1)
						day_c.hundreds <= {bit_in, day_c.hundreds[1]};
				end
				4'd5: begin
					if (idx_units <= 4'd3)
						year_c.units <= {bit_in, year_c.units[3:1]};
					else if (idx_units inside {[4'd5:4'd8]})
						year_c.tens <= {bit_in, year_c.tens[3:1]};
				end
				default: ;   // control and binary seconds fields ignored
			endcase
		end
	end

	// outputs change only with frame_done
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			sec  <= '0;
			min  <= '0;
			hour <= '0;
			day  <= '0;
			year <= '0;
		end else if (take && last_elem) begin
			sec  <= sec_c;
			min  <= min_c;
			hour <= hour_c;
			day  <= day_c;
			year <= year_c;
		end
	end

endmodule

//--- verilog/irig_sym_pkg.sv
package irig_sym_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line element classes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		sym_zero = 2'd0,   // short high time
		sym_one  = 2'd1,   // medium high time
		sym_mark = 2'd2,   // position marker
		sym_bad  = 2'd3    // too long, line fault
	} sym_e;

endpackage

//--- verilog/irig_symbol_decode.sv
`timescale 1ns/1ps

`include "irig_defines.svh"

module irig_symbol_decode (
	input  logic                clk_125mhz,
	input  logic                rst_n,
	input  logic                irig_in,
	output logic                sym_valid,
	output irig_sym_pkg::sym_e  sym
);

	logic                   sync_1;
	logic                   sync_2;
	logic                   line_d;
	logic                   line_fall;
	logic [`IRIG_CNT_W-1:0] high_cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// synchronizer and falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			line_d <= 1'b0;
		end else begin
			sync_1 <= irig_in;
			sync_2 <= sync_1;
			line_d <= sync_2;   // previous synchronized level
		end
	end

	assign line_fall = line_d && !sync_2;

	// high time, saturates on a stuck-high line
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			high_cnt <= '0;
		end else if (!sync_2) begin
			high_cnt <= '0;
		end else if (high_cnt != '1) begin
			high_cnt <= high_cnt + `IRIG_CNT_W'(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// classify on the falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			sym_valid <= 1'b0;
			sym       <= irig_sym_pkg::sym_zero;
		end else begin
			sym_valid <= line_fall;
			if (line_fall) begin
				if (high_cnt < `IRIG_CNT_W'(`IRIG_THR_01))
					sym <= irig_sym_pkg::sym_zero;
				else if (high_cnt < `IRIG_CNT_W'(`IRIG_THR_1P))
					sym <= irig_sym_pkg::sym_one;
				else if (high_cnt < `IRIG_CNT_W'(`IRIG_THR_MAX))
					sym <= irig_sym_pkg::sym_mark;
				else
					sym <= irig_sym_pkg::sym_bad;
			end
		end
	end

endmodule

//--- verilog/irig_time_pkg.sv
package irig_time_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// BCD time fields, most significant digit first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [2:0] tens;
		logic [3:0] units;
	} sec_bcd_t;

	typedef struct packed {
		logic [2:0] tens;
		logic [3:0] units;
	} min_bcd_t;

	typedef struct packed {
		logic [1:0] tens;
		logic [3:0] units;
	} hour_bcd_t;

	typedef struct packed {
		logic [1:0] hundreds;
		logic [3:0] tens;
		logic [3:0] units;
	} day_bcd_t;   // day of year

	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] units;
	} year_bcd_t;  // two-digit year

endpackage

//--- verilog/irig_time_result.sv
`timescale 1ns/1ps

module irig_time_result (
	input  logic                      clk_125mhz,
	input  logic                      rst_n,
	input  logic                      frame_done,
	input  logic                      frame_ok,
	input  irig_time_pkg::sec_bcd_t   sec,
	input  irig_time_pkg::min_bcd_t   min,
	input  irig_time_pkg::hour_bcd_t  hour,
	input  irig_time_pkg::day_bcd_t   day,
	input  irig_time_pkg::year_bcd_t  year,
	output logic                      tm_valid,
	input  logic                      tm_ready,
	output irig_time_pkg::sec_bcd_t   tm_sec,
	output irig_time_pkg::min_bcd_t   tm_min,
	output irig_time_pkg::hour_bcd_t  tm_hour,
	output irig_time_pkg::day_bcd_t   tm_day,
	output irig_time_pkg::year_bcd_t  tm_year,
	output logic                      frame_err,
	output logic                      overrun
);

	logic digits_ok;
	logic sec_ok;
	logic min_ok;
	logic hour_ok;
	logic day_ok;
	logic in_range;
	logic good;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// calendar range check
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign digits_ok = (sec.units <= 4'd9) && (min.units <= 4'd9) &&
		(hour.units <= 4'd9) && (day.units <= 4'd9) && (day.tens <= 4'd9) &&
		(year.units <= 4'd9) && (year.tens <= 4'd9);
	assign sec_ok  = (sec.tens <= 3'd5);   // 0..59
	assign min_ok  = (min.tens <= 3'd5);
	assign hour_ok = (hour.tens < 2'd2) || ((hour.tens == 2'd2) && (hour.units <= 4'd3));
	assign day_ok  = (day != '0) && ((day.hundreds < 2'd3) ||
		((day.hundreds == 2'd3) && ((day.tens < 4'd6) ||
		((day.tens == 4'd6) && (day.units <= 4'd6)))));   // 1..366

	assign in_range = digits_ok && sec_ok && min_ok && hour_ok && day_ok;
	assign good     = frame_done && frame_ok && in_range;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// record hold and output handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			tm_valid  <= 1'b0;
			frame_err <= 1'b0;
			overrun   <= 1'b0;
			tm_sec    <= '0;
			tm_min    <= '0;
			tm_hour   <= '0;
			tm_day    <= '0;
			tm_year   <= '0;
		end else begin
			frame_err <= frame_done && !(frame_ok && in_range);
			overrun   <= good && tm_valid && !tm_ready;   // held record lost
			if (good) begin
				tm_valid <= 1'b1;
				tm_sec   <= sec;
				tm_min   <= min;
				tm_hour  <= hour;
				tm_day   <= day;
				tm_year  <= year;
			end else if (tm_valid && tm_ready) begin
				tm_valid <= 1'b0;
			end
		end
	end

endmodule
